// File: source/adc_fifo_pkg.sv
package adc_fifo_pkg;

   localparam int sample_width = 10;
   typedef logic [sample_width-1:0] adc_sample_t;   // One ADC conversion

   localparam int bytecnt_width = 2;

   // Register map of the capture subsystem
   localparam logic [7:0] reg_adc_read        = 8'd3;    // FIFO data byte
   localparam logic [7:0] reg_fifo_stat       = 8'd11;
   localparam logic [7:0] reg_adc_low_res     = 8'd16;
   localparam logic [7:0] reg_sample_count    = 8'd17;   // 2 bytes, LSB first
   localparam logic [7:0] reg_arm             = 8'd18;
   localparam logic [7:0] reg_underflow_count = 8'd20;
   localparam logic [7:0] reg_fast_read_mode  = 8'd21;
   localparam logic [7:0] reg_capture_done    = 8'd22;

   // Bit positions in the FIFO status byte
   localparam int stat_overflow_bit  = 0;
   localparam int stat_underflow_bit = 1;
   localparam int stat_empty_bit     = 2;
   localparam int stat_capturing_bit = 3;

   localparam logic [15:0] sample_count_default = 16'd32;

endpackage

// File: source/sample_fifo_if.sv
interface sample_fifo_if
   import adc_fifo_pkg::*;
();

   logic        wr_en;
   adc_sample_t wr_data;
   logic        full;
   logic        rd_en;
   adc_sample_t rd_data;   // Head entry, 0 when empty
   logic        empty;

   modport writer (output wr_en, output wr_data, input full);

   modport reader (output rd_en, input rd_data, input empty);

   modport fifo (
      input  wr_en, input wr_data, output full,
      input  rd_en, output rd_data, output empty
   );

endinterface

// File: source/adc_sample_capture.sv
module adc_sample_capture
   import adc_fifo_pkg::*;
(
   input  logic          clk_usb,
   input  logic          reset,
   input  adc_sample_t   adc_data,
   input  logic          adc_valid,
   input  logic          arm,
   input  logic [15:0]   sample_count,
   sample_fifo_if.writer fifo,
   output logic          capture_done,
   output logic          capturing
);

   logic [15:0] remaining;   // Samples still to be taken
   logic        take;

   assign take         = capturing & adc_valid;
   assign fifo.wr_en   = take;
   assign fifo.wr_data = adc_data;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         capturing    <= 1'b0;
         capture_done <= 1'b0;
         remaining    <= '0;
      end else if (arm) begin
         remaining    <= sample_count;
         // A zero-length request completes at once
         capturing    <= (sample_count != 16'd0);
         capture_done <= (sample_count == 16'd0);
      end else if (take) begin
         remaining <= remaining - 16'd1;
         if (remaining == 16'd1) begin   // Last requested sample
            capturing    <= 1'b0;
            capture_done <= 1'b1;
         end
      end
   end

   // Arm comes from a single register write and must be a pulse
   assert property (@(posedge clk_usb) disable iff (reset) arm |=> !arm)
      else $error("arm held high for more than one cycle");

endmodule

// File: source/sample_fifo.sv
module sample_fifo
   import adc_fifo_pkg::*;
#(
   parameter int FIFO_DEPTH_LOG2 = 6
)(
   input  logic        clk_usb,
   input  logic        reset,
   input  logic        clear_errors,
   sample_fifo_if.fifo fifo,
   output logic        overflow_error,
   output logic        underflow_error,
   output logic [7:0]  underflow_count
);

   localparam int depth = 2 ** FIFO_DEPTH_LOG2;
   localparam logic [FIFO_DEPTH_LOG2-1:0] ptr_one   = 1;
   localparam logic [FIFO_DEPTH_LOG2:0]   count_one = 1;
   localparam logic [FIFO_DEPTH_LOG2:0]   count_max = (FIFO_DEPTH_LOG2 + 1)'(depth);

   adc_sample_t                mem [depth];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [FIFO_DEPTH_LOG2:0]   count;   // Occupancy, 0 to depth
   logic                       push;
   logic                       pop;

   assign fifo.empty   = (count == '0);
   assign fifo.full    = count[FIFO_DEPTH_LOG2];   // MSB only set at exactly depth
   assign fifo.rd_data = fifo.empty ? '0 : mem[rd_ptr];   // Fall-through head

   assign push = fifo.wr_en & ~fifo.full;
   assign pop  = fifo.rd_en & ~fifo.empty;

   always_ff @(posedge clk_usb) begin
      if (push)
         mem[wr_ptr] <= fifo.wr_data;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + ptr_one;
         if (pop)
            rd_ptr <= rd_ptr + ptr_one;
         case ({push, pop})
            2'b10:   count <= count + count_one;
            2'b01:   count <= count - count_one;
            default: ;   // Idle, or push and pop together
         endcase
      end
   end

   // Sticky error flags, held clear while clear_errors is high
   always_ff @(posedge clk_usb) begin
      if (reset || clear_errors) begin
         overflow_error  <= 1'b0;
         underflow_error <= 1'b0;
         underflow_count <= 8'd0;
      end else begin
         if (fifo.wr_en && fifo.full)
            overflow_error <= 1'b1;   // Sample dropped
         if (fifo.rd_en && fifo.empty) begin
            underflow_error <= 1'b1;
            if (underflow_count != 8'hff)
               underflow_count <= underflow_count + 8'd1;
         end
      end
   end

   assert property (@(posedge clk_usb) disable iff (reset) count <= count_max)
      else $error("FIFO occupancy above depth");

   // Pointer distance must agree with the occupancy count
   assert property (@(posedge clk_usb) disable iff (reset)
      (wr_ptr - rd_ptr) == count[FIFO_DEPTH_LOG2-1:0])
      else $error("FIFO pointers disagree with occupancy");

endmodule

// File: source/reg_adc_fifo.sv
module reg_adc_fifo
   import adc_fifo_pkg::*;
(
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic [7:0]               reg_address,
   input  logic [bytecnt_width-1:0] reg_bytecnt,
   input  logic [7:0]               reg_datai,
   input  logic                     reg_read,
   input  logic                     reg_write,
   output logic [7:0]               reg_datao,
   input  logic                     capture_done,
   input  logic                     capturing,
   input  logic                     overflow_error,
   input  logic                     underflow_error,
   input  logic [7:0]               underflow_count,
   input  logic                     fifo_empty,
   input  logic [7:0]               read_byte,
   output logic                     low_res,
   output logic [15:0]              sample_count,
   output logic                     arm,
   output logic                     clear_errors,
   output logic                     read_strobe
);

   logic       fast_read_mode;
   logic       reg_read_r;          // reg_read delayed one cycle
   logic       strobe_r;            // Normal mode strobe
   logic       data_read_start;     // First cycle of a data register read
   logic [7:0] fifo_stat;
   logic [7:0] sample_count_byte;

   assign data_read_start = reg_read & ~reg_read_r & (reg_address == reg_adc_read);

   // Fast mode saves a cycle by popping during the first read cycle
   assign read_strobe = fast_read_mode ? data_read_start : strobe_r;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_read_r <= 1'b0;
         strobe_r   <= 1'b0;
      end else begin
         reg_read_r <= reg_read;
         strobe_r   <= data_read_start;
      end
   end

   always_comb begin
      fifo_stat = 8'h00;
      fifo_stat[stat_overflow_bit]  = overflow_error;
      fifo_stat[stat_underflow_bit] = underflow_error;
      fifo_stat[stat_empty_bit]     = fifo_empty;
      fifo_stat[stat_capturing_bit] = capturing;
   end

   assign sample_count_byte = reg_bytecnt[1] ? 8'h00 :
                              reg_bytecnt[0] ? sample_count[15:8] : sample_count[7:0];

   always_comb begin
      reg_datao = 8'h00;
      if (reg_read) begin
         case (reg_address)
            reg_fifo_stat:       reg_datao = fifo_stat;
            reg_adc_low_res:     reg_datao = {7'b0, low_res};
            reg_sample_count:    reg_datao = sample_count_byte;
            reg_underflow_count: reg_datao = underflow_count;
            reg_fast_read_mode:  reg_datao = {7'b0, fast_read_mode};
            reg_capture_done:    reg_datao = {7'b0, capture_done};
            reg_adc_read:        reg_datao = read_byte;   // Byte before the advance
            default:             reg_datao = 8'h00;
         endcase
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         low_res      <= 1'b0;
         sample_count <= sample_count_default;
         clear_errors <= 1'b0;
      end else if (reg_write) begin
         case (reg_address)
            reg_adc_low_res: low_res      <= reg_datai[0];
            reg_fifo_stat:   clear_errors <= reg_datai[0];   // Level, not a pulse
            reg_sample_count: begin
               if (reg_bytecnt == 2'd0)
                  sample_count[7:0] <= reg_datai;
               else if (reg_bytecnt == 2'd1)
                  sample_count[15:8] <= reg_datai;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         arm            <= 1'b0;
         fast_read_mode <= 1'b0;
      end else begin
         arm <= reg_write & (reg_address == reg_arm) & reg_datai[0];
         // Any write elsewhere drops back to normal reads
         if (reg_write)
            fast_read_mode <= (reg_address == reg_fast_read_mode) & reg_datai[0];
      end
   end

   // Covers normal mode too, where the strobe lands one cycle into the read
   assert property (@(posedge clk_usb) disable iff (reset)
      read_strobe |-> reg_read && (reg_address == reg_adc_read))
      else $error("FIFO read strobe outside a data register read");

endmodule

// File: source/adc_byte_formatter.sv
module adc_byte_formatter
   import adc_fifo_pkg::*;
(
   input  logic          clk_usb,
   input  logic          reset,
   input  logic          low_res,
   input  logic          read_strobe,
   sample_fifo_if.reader fifo,
   output logic [7:0]    read_byte
);

   // Full mode byte select, high byte first
   logic phase;

   always_comb begin
      if (low_res)
         read_byte = fifo.rd_data[sample_width-1 -: 8];   // Drop the two LSBs
      else if (phase)
         read_byte = fifo.rd_data[7:0];
      else
         read_byte = 8'(fifo.rd_data[sample_width-1:8]);
   end

   // Full mode only pops once both bytes have gone out
   assign fifo.rd_en = read_strobe & (low_res | phase);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         phase <= 1'b0;
      end else if (low_res) begin
         phase <= 1'b0;   // Full mode always restarts on the high byte
      end else if (read_strobe) begin
         phase <= ~phase;
      end
   end

endmodule

// File: source/adc_fifo_top.sv
module adc_fifo_top
   import adc_fifo_pkg::*;
#(
   parameter int FIFO_DEPTH_LOG2 = 6
)(
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic [7:0]               reg_address,
   input  logic [bytecnt_width-1:0] reg_bytecnt,
   input  logic [7:0]               reg_datai,
   output logic [7:0]               reg_datao,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  adc_sample_t              adc_data,
   input  logic                     adc_valid
);

   logic        low_res;
   logic [15:0] sample_count;
   logic        arm;
   logic        clear_errors;
   logic        read_strobe;
   logic        capture_done;
   logic        capturing;
   logic        overflow_error;
   logic        underflow_error;
   logic [7:0]  underflow_count;
   logic [7:0]  read_byte;

   sample_fifo_if fifo_if ();

   adc_sample_capture u_capture (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .adc_data     (adc_data),
      .adc_valid    (adc_valid),
      .arm          (arm),
      .sample_count (sample_count),
      .fifo         (fifo_if),
      .capture_done (capture_done),
      .capturing    (capturing)
   );

   sample_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_fifo (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .clear_errors    (clear_errors),
      .fifo            (fifo_if),
      .overflow_error  (overflow_error),
      .underflow_error (underflow_error),
      .underflow_count (underflow_count)
   );

   reg_adc_fifo u_regs (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address     (reg_address),
      .reg_bytecnt     (reg_bytecnt),
      .reg_datai       (reg_datai),
      .reg_read        (reg_read),
      .reg_write       (reg_write),
      .reg_datao       (reg_datao),
      .capture_done    (capture_done),
      .capturing       (capturing),
      .overflow_error  (overflow_error),
      .underflow_error (underflow_error),
      .underflow_count (underflow_count),
      .fifo_empty      (fifo_if.empty),
      .read_byte       (read_byte),
      .low_res         (low_res),
      .sample_count    (sample_count),
      .arm             (arm),
      .clear_errors    (clear_errors),
      .read_strobe     (read_strobe)
   );

   adc_byte_formatter u_formatter (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .low_res     (low_res),
      .read_strobe (read_strobe),
      .fifo        (fifo_if),
      .read_byte   (read_byte)
   );

endmodule

// File: testbench/adc_fifo_checker.sv
module adc_fifo_checker (
   input logic       clk_usb,
   input logic       reg_read,
   input logic [7:0] reg_address,
   input logic [7:0] reg_datao
);

   // Expected bytes in read order, each with the name of its check
   string      exp_name [$];
   logic [7:0] exp_value [$];

   logic read_prev   = 1'b0;   // reg_read at the previous falling edge
   int   errors      = 0;
   int   test_errors = 0;
   int   tests_run   = 0;
   int   tests_failed = 0;

   // One compare per read, at the first falling edge of the reg_read level
   always @(negedge clk_usb) begin
      if (reg_read && !read_prev && exp_value.size() != 0) begin
         if (reg_datao !== exp_value[0]) begin
            $display("MISMATCH %s (address %0d): expected 0x%02h, actual 0x%02h",
                     exp_name[0], reg_address, exp_value[0], reg_datao);
            test_errors++;
            errors++;
         end
         exp_name.delete(0);
         exp_value.delete(0);
      end
      read_prev = reg_read;
   end

   task automatic expect_read(input string name, input logic [7:0] value);
      exp_name.push_back(name);
      exp_value.push_back(value);
   endtask

   task automatic report_failure(input string what);
      $display("ERROR %s", what);
      test_errors++;
      errors++;
   endtask

   task automatic end_test(input string name);
      if (exp_value.size() != 0) begin
         report_failure($sformatf("%s ended with %0d expected reads never seen",
                                  name, exp_value.size()));
         exp_name.delete();
         exp_value.delete();
      end
      tests_run++;
      if (test_errors == 0) begin
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s with %0d errors", name, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   task automatic print_counts();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
   endtask

endmodule

// File: testbench/tb_adc_fifo.sv
module tb_adc_fifo
   import adc_fifo_pkg::*;
();

   localparam int FIFO_DEPTH_LOG2 = 6;   // Handed down to the DUT
   localparam int fifo_depth      = 2 ** FIFO_DEPTH_LOG2;
   localparam int drive_delay     = 10;
   localparam int poll_limit      = 500;   // Status polls before giving up
   localparam logic [7:0] ovf_bit   = 8'h01 << stat_overflow_bit;
   localparam logic [7:0] unf_bit   = 8'h01 << stat_underflow_bit;
   localparam logic [7:0] empty_bit = 8'h01 << stat_empty_bit;

   logic                     clk_usb = 1'b0;
   logic                     reset;
   logic [7:0]               reg_address;
   logic [bytecnt_width-1:0] reg_bytecnt;
   logic [7:0]               reg_datai;
   logic [7:0]               reg_datao;
   logic                     reg_read;
   logic                     reg_write;
   adc_sample_t              adc_data;
   logic                     adc_valid;
   adc_sample_t              samples [$];   // Every sample driven since the last arm
   int                       i;

   adc_fifo_top #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) dut (.*);

   adc_fifo_checker chk (.clk_usb, .reg_read, .reg_address, .reg_datao);

   always #50 clk_usb = ~clk_usb;

   // Low res keeps the top eight bits, full mode sends the high byte first
   function automatic logic [7:0] expected_byte(input adc_sample_t q[$], input logic low_res,
                                                input int index);
      adc_sample_t s;
      if (low_res)
         return q[index][9:2];
      s = q[index / 2];
      if (index % 2 == 0)
         return {6'b0, s[9:8]};
      return s[7:0];
   endfunction

   task automatic bus_write(input logic [7:0] addr, input logic [1:0] cnt,
                            input logic [7:0] data);
      @(posedge clk_usb);
      #drive_delay;
      reg_address = addr;
      reg_bytecnt = cnt;
      reg_datai   = data;
      reg_write   = 1'b1;
      @(posedge clk_usb);
      #drive_delay;
      reg_write = 1'b0;
   endtask

   // Normal reads hold reg_read for two cycles, single reads for one
   task automatic bus_read(input logic [7:0] addr, input logic [1:0] cnt, input logic single,
                           output logic [7:0] data);
      @(posedge clk_usb);
      #drive_delay;
      reg_address = addr;
      reg_bytecnt = cnt;
      reg_read    = 1'b1;
      @(negedge clk_usb);
      data = reg_datao;
      if (!single)
         @(posedge clk_usb);
      @(posedge clk_usb);
      #drive_delay;
      reg_read = 1'b0;
   endtask

   task automatic check_read(input string name, input logic [7:0] addr, input logic [1:0] cnt,
                             input logic [7:0] expected, input logic single);
      logic [7:0] seen;
      chk.expect_read(name, expected);
      bus_read(addr, cnt, single, seen);
   endtask

   task automatic arm_capture(input logic [15:0] count);
      samples.delete();
      bus_write(reg_sample_count, 2'd0, count[7:0]);
      bus_write(reg_sample_count, 2'd1, count[15:8]);
      bus_write(reg_arm, 2'd0, 8'h01);
      repeat (2) @(posedge clk_usb);   // Arm pulse, then capturing
   endtask

   task automatic drive_samples(input int n);
      adc_sample_t value;
      int          k;
      for (k = 0; k < n; k++) begin
         repeat ($urandom_range(2, 0)) begin   // Random gap between samples
            @(posedge clk_usb);
            #drive_delay;
            adc_valid = 1'b0;
         end
         @(posedge clk_usb);
         #drive_delay;
         value     = adc_sample_t'($urandom);
         adc_data  = value;
         adc_valid = 1'b1;
         samples.push_back(value);
      end
      @(posedge clk_usb);
      #drive_delay;
      adc_valid = 1'b0;
   endtask

   task automatic finish_run();
      chk.print_counts();
      if (chk.errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   task automatic wait_capture_done(input string name);
      logic [7:0] value;
      int         polls;
      value = 8'h00;
      polls = 0;
      while (value[0] !== 1'b1 && polls < poll_limit) begin
         bus_read(reg_capture_done, 2'd0, 1'b1, value);
         polls++;
      end
      if (value[0] !== 1'b1)
         chk.report_failure($sformatf("%s timed out waiting for capture_done", name));
   endtask

   initial begin
      void'($urandom(32'he9af_06a5));
      reset       = 1'b1;
      reg_address = 8'h00;
      reg_bytecnt = '0;
      reg_datai   = 8'h00;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      adc_data    = '0;
      adc_valid   = 1'b0;
      repeat (16) @(posedge clk_usb);
      #drive_delay;
      reset = 1'b0;

      check_read("default count low", reg_sample_count, 2'd0, 8'd32, 1'b0);
      check_read("default count high", reg_sample_count, 2'd1, 8'd0, 1'b0);
      check_read("default low res", reg_adc_low_res, 2'd0, 8'd0, 1'b0);
      check_read("default fast mode", reg_fast_read_mode, 2'd0, 8'd0, 1'b0);
      check_read("default capture done", reg_capture_done, 2'd0, 8'd0, 1'b0);
      check_read("default status", reg_fifo_stat, 2'd0, empty_bit, 1'b0);
      chk.end_test("reset defaults");

      arm_capture(16'd20);
      drive_samples(20);
      wait_capture_done("full resolution");
      for (i = 0; i < 40; i++)
         check_read($sformatf("full res byte %0d", i), reg_adc_read, 2'd0,
                    expected_byte(samples, 1'b0, i), 1'b0);
      check_read("full res drained", reg_fifo_stat, 2'd0, empty_bit, 1'b0);
      chk.end_test("full resolution capture");

      bus_write(reg_adc_low_res, 2'd0, 8'h01);
      arm_capture(16'd16);
      drive_samples(16);
      wait_capture_done("low resolution fast");
      bus_write(reg_fast_read_mode, 2'd0, 8'h01);   // Last write before the reads
      check_read("fast mode set", reg_fast_read_mode, 2'd0, 8'd1, 1'b0);
      for (i = 0; i < 16; i++)
         check_read($sformatf("low res byte %0d", i), reg_adc_read, 2'd0,
                    expected_byte(samples, 1'b1, i), 1'b1);
      bus_write(reg_adc_low_res, 2'd0, 8'h01);
      check_read("fast mode cleared", reg_fast_read_mode, 2'd0, 8'd0, 1'b0);
      chk.end_test("low resolution fast read");

      arm_capture(16'(fifo_depth + 6));
      drive_samples(fifo_depth + 6);
      wait_capture_done("overflow");
      check_read("overflow flagged", reg_fifo_stat, 2'd0, ovf_bit, 1'b0);
      for (i = 0; i < fifo_depth; i++)
         check_read($sformatf("overflow byte %0d", i), reg_adc_read, 2'd0,
                    expected_byte(samples, 1'b1, i), 1'b0);
      check_read("overflow sticky", reg_fifo_stat, 2'd0, ovf_bit | empty_bit, 1'b0);
      bus_write(reg_fifo_stat, 2'd0, 8'h01);
      bus_write(reg_fifo_stat, 2'd0, 8'h00);
      check_read("overflow cleared", reg_fifo_stat, 2'd0, empty_bit, 1'b0);
      chk.end_test("overflow");

      for (i = 0; i < 3; i++)
         check_read($sformatf("underflow byte %0d", i), reg_adc_read, 2'd0, 8'd0, 1'b0);
      check_read("underflow flagged", reg_fifo_stat, 2'd0, unf_bit | empty_bit, 1'b0);
      check_read("underflow count", reg_underflow_count, 2'd0, 8'd3, 1'b0);
      chk.end_test("underflow");

      finish_run();
   end

endmodule

// File: sources.f
source/adc_fifo_pkg.sv
source/sample_fifo_if.sv
source/adc_sample_capture.sv
source/sample_fifo.sv
source/reg_adc_fifo.sv
source/adc_byte_formatter.sv
source/adc_fifo_top.sv
testbench/adc_fifo_checker.sv
testbench/tb_adc_fifo.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_fifo
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
